//--- all.f
verilog/issue_pkg.sv
verilog/ready_table.sv
verilog/rs_way.sv
verilog/phys_regfile.sv
verilog/alu_unit.sv
verilog/mul_unit.sv
verilog/issue_core.sv
verif/issue_core_properties.sv
verif/issue_core_tb.sv

//--- run.sh
#!/bin/sh
# Build the issue stage testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f all.f --top-module issue_core_tb \
        -Mdir obj_dir -o sim_issue_core; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_issue_core)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1

//--- verif/issue_core_properties.sv
module issue_core_properties
    import issue_pkg::*;
(
    input logic clk,
    input logic rst,
    input logic table_full,
    input cdb_t cdb [CDB_PORTS]
);

    logic [CDB_PORTS-1:0] cdb_valid;
    logic [SS-1:0]        mul_valid;
    logic                 dup_tag;

    // Flatten the bus and look for a tag on two slots
    always_comb begin
        dup_tag = 1'b0;
        for (int k = 0; k < CDB_PORTS; k++) begin
            cdb_valid[k] = cdb[k].valid;
            for (int j = k + 1; j < CDB_PORTS; j++) begin
                if (cdb[k].valid && cdb[j].valid && cdb[k].tag == cdb[j].tag) begin
                    dup_tag = 1'b1;
                end
            end
        end
        for (int w = 0; w < SS; w++) begin
            mul_valid[w] = cdb[2*w+1].valid;
        end
    end

    // One producer per outstanding tag
    a_unique_tag: assert property (@(posedge clk) disable iff (rst) !dup_tag)
        else $error("two CDB slots carry the same tag");

    a_reset_idle: assert property (@(posedge clk) rst |=> (cdb_valid == '0 && !table_full))
        else $error("CDB or table_full active in the cycle after reset");

    // Multiplier is not pipelined
    for (genvar w = 0; w < SS; w++) begin : g_mul
        a_mul_gap: assert property (@(posedge clk) disable iff (rst)
                                    mul_valid[w] |=> !mul_valid[w])
            else $error("multiply slot of way %0d valid in consecutive cycles", w);
    end

endmodule

bind issue_core issue_core_properties u_props (
    .clk        (clk),
    .rst        (rst),
    .table_full (table_full),
    .cdb        (cdb)
);

//--- verif/issue_core_tb.sv
module issue_core_tb
    import issue_pkg::*;
();

    localparam int NUM_PAIRS    = 300;
    localparam int DRAIN_MARGIN = 1000;
    // Quiet cycles after the drain, to catch stray broadcasts
    localparam int TAIL_CYCLES  = 20;
    // Worst case per pair is a full table waiting on one multiplier
    localparam int MAX_CYCLES   = NUM_PAIRS * (MUL_LATENCY + 2) * 2 * RS_DEPTH + DRAIN_MARGIN;

    logic      clk = 1'b0;
    logic      rst;
    logic      avail_inst;
    dispatch_t dispatch [SS];
    logic      table_full;
    cdb_t      cdb [CDB_PORTS];

    // Reference model, indexed by physical tag
    logic [XLEN-1:0]  val [PREG_COUNT];
    logic             pending [PREG_COUNT];
    int               readers [PREG_COUNT];
    int               exp_slot [PREG_COUNT];
    logic [TAG_W-1:0] src_a [PREG_COUNT];
    logic [TAG_W-1:0] src_b [PREG_COUNT];
    logic [TAG_W-1:0] recent [4];
    logic [XLEN-1:0]  gen_val [SS];

    logic [15:0] lfsr;
    logic        full_seen;
    logic        held;
    int          cycles;
    int          pairs_done;
    int          pending_cnt;
    int          broadcasts;
    int          value_errs;
    int          other_errs;

    issue_core DUT (
        .clk        (clk),
        .rst        (rst),
        .avail_inst (avail_inst),
        .dispatch   (dispatch),
        .table_full (table_full),
        .cdb        (cdb)
    );

    always #5 clk = ~clk;

    // 16-bit Galois LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // Expected result straight from the instruction rules
    function automatic logic [XLEN-1:0] expected_result(input logic is_mul, input alu_op_e op,
                                                       input logic [XLEN-1:0] a,
                                                       input logic [XLEN-1:0] b);
        logic [2*XLEN-1:0] prod;
        logic [XLEN-1:0]   diff;
        logic [XLEN-1:0]   res;
        logic              lt;
        prod = (2*XLEN)'(a) * (2*XLEN)'(b);
        diff = a + ~b + XLEN'(1);
        // Signs differ: negative one is smaller, else sign of the difference
        lt   = (a[XLEN-1] != b[XLEN-1]) ? a[XLEN-1] : diff[XLEN-1];
        case (op)
            ALU_ADD: res = a + b;
            ALU_SUB: res = diff;
            ALU_XOR: res = a ^ b;
            default: res = {{(XLEN-1){1'b0}}, lt};
        endcase
        if (is_mul) begin
            res = prod[XLEN-1:0];
        end
        return res;
    endfunction

    // Rename one pair onto free tags, ok low when too few are free
    task automatic build_pair(output logic ok);
        logic [TAG_W-1:0] dest [SS];
        logic [TAG_W-1:0] hist [4];
        logic [TAG_W-1:0] start;
        logic [TAG_W-1:0] t;
        logic [XLEN-1:0]  a;
        logic [XLEN-1:0]  b;
        logic [7:0]       imm8;
        logic [1:0]       idx;
        int               found;
        dispatch_t        d;
        found = 0;
        start = TAG_W'(rand_bits(TAG_W));
        // Free means value known and nobody still reads the old one
        for (int i = 0; i < PREG_COUNT; i++) begin
            t = start + TAG_W'(i);
            if (found < SS && t != '0 && !pending[t] && readers[t] == 0 &&
                !(found == 1 && t == dest[0])) begin
                dest[found] = t;
                found++;
            end
        end
        ok = (found == SS);
        if (!ok) begin
            return;
        end
        hist = recent;
        for (int w = 0; w < SS; w++) begin
            d.is_mul  = 1'(rand_bits(1));
            d.alu_op  = alu_op_e'(rand_bits(2));
            d.use_imm = 1'(rand_bits(1));
            imm8      = 8'(rand_bits(8));
            d.imm     = {{(XLEN-8){imm8[7]}}, imm8};
            for (int s = 0; s < 2; s++) begin
                // Mostly a recent dest, so chains form
                if (rand_bits(3) == 0) begin
                    t = TAG_W'(rand_bits(TAG_W));
                end else begin
                    idx = 2'(rand_bits(2));
                    t   = hist[idx];
                end
                // Never read a dest allocated by this way or a younger one
                for (int j = w; j < SS; j++) begin
                    if (t == dest[j]) begin
                        t = '0;
                    end
                end
                if (s == 0) begin
                    d.src1 = t;
                end else begin
                    d.src2 = t;
                end
            end
            if (d.use_imm) begin
                d.src2 = '0;
            end
            d.dest = dest[w];
            a = val[d.src1];
            b = d.use_imm ? d.imm : val[d.src2];
            // Older way of the same pair already produced its value
            for (int j = 0; j < w; j++) begin
                if (d.src1 == dest[j]) begin
                    a = gen_val[j];
                end
                if (!d.use_imm && d.src2 == dest[j]) begin
                    b = gen_val[j];
                end
            end
            gen_val[w]  = expected_result(d.is_mul, d.alu_op, a, b);
            dispatch[w] = d;
            hist        = '{d.dest, hist[0], hist[1], hist[2]};
        end
    endtask

    // Record an accepted pair in the model
    task automatic commit_pair();
        logic [TAG_W-1:0] d;
        for (int w = 0; w < SS; w++) begin
            d           = dispatch[w].dest;
            pending[d]  = 1'b1;
            val[d]      = gen_val[w];
            exp_slot[d] = 2 * w + (dispatch[w].is_mul ? 1 : 0);
            src_a[d]    = dispatch[w].src1;
            src_b[d]    = dispatch[w].src2;
            readers[dispatch[w].src1]++;
            readers[dispatch[w].src2]++;
            recent      = '{d, recent[0], recent[1], recent[2]};
            pending_cnt++;
        end
        pairs_done++;
    endtask

    // Check and retire every valid broadcast of this cycle
    task automatic check_cdb();
        logic [TAG_W-1:0] t;
        for (int k = 0; k < CDB_PORTS; k++) begin
            if (cdb[k].valid) begin
                t = cdb[k].tag;
                broadcasts++;
                if (!pending[t]) begin
                    $display("Slot %0d broadcast tag %0d with no instruction in flight", k, t);
                    other_errs++;
                end else begin
                    if (cdb[k].value != val[t]) begin
                        $display("FAILED cdb_value tag %0d: expected %h, actual %h",
                                 t, val[t], cdb[k].value);
                        value_errs++;
                    end
                    if (k != exp_slot[t]) begin
                        $display("FAILED cdb_slot tag %0d: expected %0d, actual %0d",
                                 t, exp_slot[t], k);
                        value_errs++;
                    end
                    pending[t] = 1'b0;
                    readers[src_a[t]]--;
                    readers[src_b[t]]--;
                    pending_cnt--;
                end
            end
        end
    endtask

    initial begin
        logic ok;
        int   tail;
        rst        = 1'b1;
        avail_inst = 1'b0;
        for (int w = 0; w < SS; w++) begin
            dispatch[w] = '0;
        end
        lfsr = 16'd14622;
        // All registers start at zero and ready
        for (int t = 0; t < PREG_COUNT; t++) begin
            val[t]     = '0;
            pending[t] = 1'b0;
            readers[t] = 0;
        end
        recent      = '{default: '0};
        full_seen   = 1'b0;
        held        = 1'b0;
        cycles      = 0;
        pairs_done  = 0;
        pending_cnt = 0;
        broadcasts  = 0;
        value_errs  = 0;
        other_errs  = 0;
        tail        = 0;

        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        // Idle state right after reset
        if (table_full) begin
            $display("table_full is high right after reset");
            other_errs++;
        end
        for (int k = 0; k < CDB_PORTS; k++) begin
            if (cdb[k].valid) begin
                $display("CDB slot %0d is valid right after reset", k);
                other_errs++;
            end
        end

        // Sample mid-cycle, drive 1 unit after the rising edge
        while (tail < TAIL_CYCLES && cycles < MAX_CYCLES) begin
            @(negedge clk);
            check_cdb();
            if (table_full) begin
                full_seen = 1'b1;
            end
            // Pair on the inputs is taken at the coming edge
            if (avail_inst && !table_full) begin
                commit_pair();
                held = 1'b0;
            end
            @(posedge clk);
            #1;
            // A refused pair stays on the inputs
            if (!held) begin
                avail_inst = 1'b0;
                if (pairs_done < NUM_PAIRS && rand_bits(2) != 0) begin
                    build_pair(ok);
                    avail_inst = ok;
                    held       = ok;
                end
            end
            if (pairs_done == NUM_PAIRS && pending_cnt == 0) begin
                tail++;
            end
            cycles++;
        end

        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, %0d pairs dispatched, %0d tags in flight",
                     cycles, pairs_done, pending_cnt);
            other_errs++;
        end
        for (int t = 0; t < PREG_COUNT; t++) begin
            if (pending[t]) begin
                $display("Tag %0d never broadcast its result", t);
                other_errs++;
            end
        end
        if (!full_seen) begin
            $display("table_full never went high, back-pressure was not exercised");
            other_errs++;
        end
        $display("Summary: %0d pairs, %0d broadcasts, %0d value errors, %0d other errors",
                 pairs_done, broadcasts, value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- verilog/alu_unit.sv
module alu_unit
    import issue_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  issue_t          issue,
    input  logic [XLEN-1:0] op_a,
    input  logic [XLEN-1:0] op_b,
    output cdb_t            result
);

    logic [XLEN-1:0] op_b_sel;
    logic [XLEN-1:0] alu_out;

    // Second operand is the immediate or the register
    assign op_b_sel = issue.use_imm ? issue.imm : op_b;

    always_comb begin
        case (issue.alu_op)
            ALU_ADD: alu_out = op_a + op_b_sel;
            ALU_SUB: alu_out = op_a - op_b_sel;
            ALU_XOR: alu_out = op_a ^ op_b_sel;
            // Signed compare gives 1 or 0
            ALU_SLT: alu_out = ($signed(op_a) < $signed(op_b_sel)) ? XLEN'(1) : '0;
            default: alu_out = '0;
        endcase
    end

    // Broadcast one edge after issue
    always_ff @(posedge clk) begin
        if (rst) begin
            result.valid <= 1'b0;
        end else begin
            // Multiplies belong to the other unit
            result.valid <= issue.valid && !issue.is_mul;
            result.tag   <= issue.dest;
            result.value <= alu_out;
        end
    end

endmodule

//--- verilog/issue_core.sv
module issue_core
    import issue_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      avail_inst,
    input  dispatch_t dispatch [SS],
    output logic      table_full,
    output cdb_t      cdb [CDB_PORTS]
);

    logic             accept;
    logic             way_full [SS];
    logic             src_ready [SS][2];
    logic             mul_busy [SS];
    issue_t           issue [SS];
    logic [TAG_W-1:0] rd_tag [RD_PORTS];
    logic [XLEN-1:0]  rd_data [RD_PORTS];

    // Any full way stalls the whole pair
    always_comb begin
        table_full = 1'b0;
        for (int w = 0; w < SS; w++) begin
            table_full = table_full | way_full[w];
        end
    end

    assign accept = avail_inst && !table_full;

    ready_table u_ready_table (
        .clk       (clk),
        .rst       (rst),
        .accept    (accept),
        .dispatch  (dispatch),
        .cdb       (cdb),
        .src_ready (src_ready)
    );

    phys_regfile u_regfile (
        .clk     (clk),
        .rst     (rst),
        .rd_tag  (rd_tag),
        .rd_data (rd_data),
        .cdb     (cdb)
    );

    // Way w owns read ports 2w, 2w+1 and CDB slots 2w (ALU), 2w+1 (MUL)
    for (genvar w = 0; w < SS; w++) begin : g_way
        rs_way u_rs_way (
            .clk       (clk),
            .rst       (rst),
            .accept    (accept),
            .entry_in  (dispatch[w]),
            .src_ready (src_ready[w]),
            .cdb       (cdb),
            .mul_busy  (mul_busy[w]),
            .issue     (issue[w]),
            .rd_tag1   (rd_tag[2*w]),
            .rd_tag2   (rd_tag[2*w+1]),
            .way_full  (way_full[w])
        );

        alu_unit u_alu (
            .clk    (clk),
            .rst    (rst),
            .issue  (issue[w]),
            .op_a   (rd_data[2*w]),
            .op_b   (rd_data[2*w+1]),
            .result (cdb[2*w])
        );

        mul_unit u_mul (
            .clk    (clk),
            .rst    (rst),
            .issue  (issue[w]),
            .op_a   (rd_data[2*w]),
            .op_b   (rd_data[2*w+1]),
            .busy   (mul_busy[w]),
            .result (cdb[2*w+1])
        );
    end

endmodule

//--- verilog/issue_pkg.sv
package issue_pkg;

    // Machine width
    localparam int SS          = 2;
    localparam int RS_DEPTH    = 8;
    localparam int PREG_COUNT  = 32;
    localparam int TAG_W       = 5;
    localparam int XLEN        = 32;
    localparam int MUL_LATENCY = 3;

    // One ALU slot and one multiply slot per way
    localparam int CDB_PORTS   = SS * 2;
    // Two source reads per way
    localparam int RD_PORTS    = SS * 2;

    // Derived widths
    localparam int RS_IDX_W    = $clog2(RS_DEPTH);
    localparam int RS_CNT_W    = $clog2(RS_DEPTH + 1);
    localparam int MUL_CNT_W   = $clog2(MUL_LATENCY);

    // ALU operations
    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_SUB = 2'd1,
        ALU_XOR = 2'd2,
        ALU_SLT = 2'd3
    } alu_op_e;

    // Renamed instruction from dispatch
    typedef struct packed {
        logic             is_mul;
        alu_op_e          alu_op;
        logic             use_imm;
        logic [XLEN-1:0]  imm;
        logic [TAG_W-1:0] src1;
        logic [TAG_W-1:0] src2;
        logic [TAG_W-1:0] dest;
    } dispatch_t;

    // Reservation table entry
    typedef struct packed {
        logic      valid;
        logic      src1_met;
        logic      src2_met;
        dispatch_t inst;
    } rs_entry_t;

    // Issue register contents, operands come from the register file
    typedef struct packed {
        logic             valid;
        logic             is_mul;
        alu_op_e          alu_op;
        logic             use_imm;
        logic [XLEN-1:0]  imm;
        logic [TAG_W-1:0] dest;
    } issue_t;

    // One broadcast slot on the common data bus
    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  value;
    } cdb_t;

endpackage

//--- verilog/mul_unit.sv
module mul_unit
    import issue_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  issue_t          issue,
    input  logic [XLEN-1:0] op_a,
    input  logic [XLEN-1:0] op_b,
    output logic            busy,
    output cdb_t            result
);

    logic [XLEN-1:0]      a_q;
    logic [XLEN-1:0]      b_q;
    logic [TAG_W-1:0]     dest_q;
    logic [MUL_CNT_W-1:0] cnt_q;
    logic [XLEN-1:0]      product;
    logic                 capture;

    // Only one multiply in flight
    assign capture = issue.valid && issue.is_mul && !busy;

    // Low half of the product
    assign product = a_q * b_q;

    // Operand capture
    always_ff @(posedge clk) begin
        if (capture) begin
            a_q    <= op_a;
            b_q    <= issue.use_imm ? issue.imm : op_b;
            dest_q <= issue.dest;
        end
    end

    // Capture is one edge after issue, so count the remaining edges
    always_ff @(posedge clk) begin
        if (rst) begin
            busy         <= 1'b0;
            cnt_q        <= '0;
            result.valid <= 1'b0;
        end else begin
            result.valid <= 1'b0;
            if (capture) begin
                busy  <= 1'b1;
                cnt_q <= MUL_CNT_W'(MUL_LATENCY - 2);
            end else if (busy) begin
                if (cnt_q == '0) begin
                    // Single-cycle broadcast ends the busy interval
                    busy         <= 1'b0;
                    result.valid <= 1'b1;
                    result.tag   <= dest_q;
                    result.value <= product;
                end else begin
                    cnt_q <= cnt_q - 1'b1;
                end
            end
        end
    end

endmodule

//--- verilog/phys_regfile.sv
module phys_regfile
    import issue_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic [TAG_W-1:0] rd_tag [RD_PORTS],
    output logic [XLEN-1:0]  rd_data [RD_PORTS],
    input  cdb_t             cdb [CDB_PORTS]
);

    logic [XLEN-1:0] regs_q [PREG_COUNT];

    // Asynchronous reads, tag 0 is zero
    always_comb begin
        for (int p = 0; p < RD_PORTS; p++) begin
            if (rd_tag[p] == '0) begin
                rd_data[p] = '0;
            end else begin
                rd_data[p] = regs_q[rd_tag[p]];
            end
        end
    end

    // Writes from every valid broadcast
    // Outstanding tags are unique, so slots never collide
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < PREG_COUNT; r++) begin
                regs_q[r] <= '0;
            end
        end else begin
            for (int k = 0; k < CDB_PORTS; k++) begin
                if (cdb[k].valid && cdb[k].tag != '0) begin
                    regs_q[cdb[k].tag] <= cdb[k].value;
                end
            end
        end
    end

endmodule

//--- verilog/ready_table.sv
module ready_table
    import issue_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      accept,
    input  dispatch_t dispatch [SS],
    input  cdb_t      cdb [CDB_PORTS],
    output logic      src_ready [SS][2]
);

    // One bit per physical tag, set means value is in the register file
    logic [PREG_COUNT-1:0] ready_q;

    // Readiness of the incoming sources
    always_comb begin
        logic [TAG_W-1:0] tag;
        logic             alloc_older;
        logic             bypass;
        for (int w = 0; w < SS; w++) begin
            for (int s = 0; s < 2; s++) begin
                tag = (s == 0) ? dispatch[w].src1 : dispatch[w].src2;
                // Dest of an older way in the same pair is not produced yet
                alloc_older = 1'b0;
                for (int j = 0; j < w; j++) begin
                    if (dispatch[j].dest == tag) begin
                        alloc_older = 1'b1;
                    end
                end
                // Same-cycle broadcast counts as ready
                bypass = 1'b0;
                for (int k = 0; k < CDB_PORTS; k++) begin
                    if (cdb[k].valid && cdb[k].tag == tag) begin
                        bypass = 1'b1;
                    end
                end
                src_ready[w][s] = (tag == '0) || bypass || (ready_q[tag] && !alloc_older);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ready_q <= '1;
        end else begin
            for (int k = 0; k < CDB_PORTS; k++) begin
                if (cdb[k].valid) begin
                    ready_q[cdb[k].tag] <= 1'b1;
                end
            end
            // Clears come last so they win over a broadcast
            if (accept) begin
                for (int w = 0; w < SS; w++) begin
                    if (dispatch[w].dest != '0) begin
                        ready_q[dispatch[w].dest] <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

//--- verilog/rs_way.sv
module rs_way
    import issue_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             accept,
    input  dispatch_t        entry_in,
    input  logic             src_ready [2],
    input  cdb_t             cdb [CDB_PORTS],
    input  logic             mul_busy,
    output issue_t           issue,
    output logic [TAG_W-1:0] rd_tag1,
    output logic [TAG_W-1:0] rd_tag2,
    output logic             way_full
);

    rs_entry_t            table_q [RS_DEPTH];
    logic [RS_CNT_W-1:0]  count_q;

    logic                 ins_found;
    logic [RS_IDX_W-1:0]  ins_idx;
    logic                 sel_found;
    logic [RS_IDX_W-1:0]  sel_idx;
    logic                 mul_block;

    // Multiply just issued is not yet captured, so block it as well
    assign mul_block = mul_busy || (issue.valid && issue.is_mul);

    // Occupancy is registered, full when no entry is free
    assign way_full = (count_q == RS_CNT_W'(RS_DEPTH));

    // Lowest free entry for insert
    always_comb begin
        ins_found = 1'b0;
        ins_idx   = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (!ins_found && !table_q[i].valid) begin
                ins_found = 1'b1;
                ins_idx   = RS_IDX_W'(i);
            end
        end
    end

    // Lowest ready entry for issue
    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (!sel_found && table_q[i].valid && table_q[i].src1_met &&
                table_q[i].src2_met && !(table_q[i].inst.is_mul && mul_block)) begin
                sel_found = 1'b1;
                sel_idx   = RS_IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                table_q[i].valid <= 1'b0;
            end
            issue.valid <= 1'b0;
            count_q     <= '0;
        end else begin
            // Wakeup from every broadcast slot
            for (int i = 0; i < RS_DEPTH; i++) begin
                for (int k = 0; k < CDB_PORTS; k++) begin
                    if (table_q[i].valid && cdb[k].valid) begin
                        if (cdb[k].tag == table_q[i].inst.src1) begin
                            table_q[i].src1_met <= 1'b1;
                        end
                        if (cdb[k].tag == table_q[i].inst.src2) begin
                            table_q[i].src2_met <= 1'b1;
                        end
                    end
                end
            end

            // Winner leaves the table
            if (sel_found) begin
                table_q[sel_idx].valid <= 1'b0;
            end

            // Insert, met bits already include CDB bypass
            if (accept && ins_found) begin
                table_q[ins_idx].inst     <= entry_in;
                table_q[ins_idx].valid    <= 1'b1;
                table_q[ins_idx].src1_met <= src_ready[0];
                table_q[ins_idx].src2_met <= src_ready[1];
            end

            // Issue register and read tags
            issue.valid   <= sel_found;
            issue.is_mul  <= table_q[sel_idx].inst.is_mul;
            issue.alu_op  <= table_q[sel_idx].inst.alu_op;
            issue.use_imm <= table_q[sel_idx].inst.use_imm;
            issue.imm     <= table_q[sel_idx].inst.imm;
            issue.dest    <= table_q[sel_idx].inst.dest;
            rd_tag1       <= table_q[sel_idx].inst.src1;
            rd_tag2       <= table_q[sel_idx].inst.src2;

            count_q <= count_q + RS_CNT_W'(accept && ins_found) - RS_CNT_W'(sel_found);
        end
    end

endmodule
